//--- wb_pkg.sv
`default_nettype none

package wb_pkg;

    localparam int ADR_W = 32;
    localparam int DAT_W = 32;

    typedef logic [DAT_W-1:0] word_t;
    typedef logic [ADR_W-1:0] adr_t;
    typedef logic [DAT_W/8-1:0] sel_t;

    // Which master currently owns the shared memory bus
    typedef enum logic [1:0] {
        arb_idle  = 2'd0,
        arb_instr = 2'd1,
        arb_data  = 2'd2
    } arb_state_t;

endpackage : wb_pkg

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int OFFSET_W = 2;                  // Byte offset inside a word
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 26;
    localparam int LINES    = 1 << INDEX_W;

    // Processor address, seen whole or split for the cache lookup
    typedef union packed {
        wb_pkg::adr_t word;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } fields;
    } cache_adr_u;

endpackage : cache_pkg

`default_nettype wire

//--- wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  wire                 wb_icache,
    input  wire                 rst,
    input  wire                 ic_cyc,
    input  wire                 ic_stb,
    input  wire                 ic_we,
    input  wire wb_pkg::adr_t   ic_adr,
    input  wire wb_pkg::sel_t   ic_sel,
    input  wire wb_pkg::word_t  ic_dat_m,
    output logic                ic_ack,
    output wb_pkg::word_t       ic_dat_s,
    input  wire                 dc_cyc,
    input  wire                 dc_stb,
    input  wire                 dc_we,
    input  wire wb_pkg::adr_t   dc_adr,
    input  wire wb_pkg::sel_t   dc_sel,
    input  wire wb_pkg::word_t  dc_dat_m,
    output logic                dc_ack,
    output wb_pkg::word_t       dc_dat_s,
    output logic                mem_cyc,
    output logic                mem_stb,
    output logic                mem_we,
    output wb_pkg::adr_t        mem_adr,
    output wb_pkg::sel_t        mem_sel,
    output wb_pkg::word_t       mem_dat_m,
    input  wire                 mem_ack,
    input  wire wb_pkg::word_t  mem_dat_s
);

    wb_pkg::arb_state_t state;
    wb_pkg::arb_state_t next_state;

    always_comb begin
        ic_ack    = 1'b0;
        ic_dat_s  = '0;
        dc_ack    = 1'b0;
        dc_dat_s  = '0;
        mem_cyc   = 1'b0;
        mem_stb   = 1'b0;
        mem_we    = 1'b0;
        mem_adr   = '0;
        mem_sel   = '0;
        mem_dat_m = '0;
        case (state)
            wb_pkg::arb_instr: begin
                ic_ack    = mem_ack;
                ic_dat_s  = mem_dat_s;
                mem_cyc   = ic_cyc;
                mem_stb   = ic_stb;
                mem_we    = ic_we;
                mem_adr   = ic_adr;
                mem_sel   = ic_sel;
                mem_dat_m = ic_dat_m;
            end
            wb_pkg::arb_data: begin
                dc_ack    = mem_ack;
                dc_dat_s  = mem_dat_s;
                mem_cyc   = dc_cyc;
                mem_stb   = dc_stb;
                mem_we    = dc_we;
                mem_adr   = dc_adr;
                mem_sel   = dc_sel;
                mem_dat_m = dc_dat_m;
            end
            default: ;                            // Idle drives nothing
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            wb_pkg::arb_idle: begin
                if (ic_stb) begin
                    next_state = wb_pkg::arb_instr;   // Fetch side wins a tie
                end else if (dc_stb) begin
                    next_state = wb_pkg::arb_data;
                end
            end
            wb_pkg::arb_instr,
            wb_pkg::arb_data: begin
                if (mem_ack) begin
                    next_state = wb_pkg::arb_idle;
                end
            end
            default: next_state = wb_pkg::arb_idle;
        endcase
    end

    always_ff @(posedge wb_icache) begin
        if (rst) begin
            state <= wb_pkg::arb_idle;
        end else begin
            state <= next_state;
        end
    end

endmodule : wb_arbiter

`default_nettype wire

//--- icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  wire                 wb_icache,
    input  wire                 rst,
    input  wire                 fetch_req,
    input  wire wb_pkg::adr_t   fetch_adr,
    output logic                fetch_ready,
    output wb_pkg::word_t       fetch_data,
    output logic                ic_cyc,
    output logic                ic_stb,
    output logic                ic_we,
    output wb_pkg::adr_t        ic_adr,
    output wb_pkg::sel_t        ic_sel,
    output wb_pkg::word_t       ic_dat_m,
    input  wire                 ic_ack,
    input  wire wb_pkg::word_t  ic_dat_s
);

    localparam logic LOOKUP = 1'b0;
    localparam logic REFILL = 1'b1;

    cache_pkg::cache_adr_u             req_adr;
    logic [cache_pkg::TAG_W-1:0]       tag_arr [cache_pkg::LINES];
    wb_pkg::word_t                     data_arr [cache_pkg::LINES];
    logic [cache_pkg::LINES-1:0]       valid;
    logic [cache_pkg::INDEX_W-1:0]     idx;
    logic                              state;
    logic                              start;
    logic                              hit;

    assign req_adr.word = fetch_adr;
    assign idx     = req_adr.fields.index;
    assign hit     = valid[idx] && (tag_arr[idx] == req_adr.fields.tag);
    assign start   = (state == LOOKUP) && fetch_req && !fetch_ready;   // New request only

    // Refill master, a single word read
    assign ic_cyc   = (state == REFILL);
    assign ic_stb   = (state == REFILL);
    assign ic_we    = 1'b0;
    assign ic_sel   = '1;
    assign ic_adr   = {req_adr.fields.tag, idx, {cache_pkg::OFFSET_W{1'b0}}};
    assign ic_dat_m = '0;

    always_ff @(posedge wb_icache) begin
        if (rst) begin
            state       <= LOOKUP;
            fetch_ready <= 1'b0;
            valid       <= '0;
        end else begin
            fetch_ready <= 1'b0;
            if (start) begin
                if (hit) begin
                    fetch_ready <= 1'b1;
                end else begin
                    state <= REFILL;
                end
            end else if (state == REFILL && ic_ack) begin
                valid[idx]  <= 1'b1;
                fetch_ready <= 1'b1;
                state       <= LOOKUP;
            end
        end
    end

    always_ff @(posedge wb_icache) begin
        if (start && hit) begin
            fetch_data <= data_arr[idx];
        end
        if (state == REFILL && ic_ack) begin
            tag_arr[idx]  <= req_adr.fields.tag;
            data_arr[idx] <= ic_dat_s;
            fetch_data    <= ic_dat_s;       // Forward the refilled word
        end
    end

endmodule : icache

`default_nettype wire

//--- dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  wire                 wb_icache,
    input  wire                 rst,
    input  wire                 data_req,
    input  wire                 data_we,
    input  wire wb_pkg::adr_t   data_adr,
    input  wire wb_pkg::word_t  data_wdata,
    output logic                data_ready,
    output wb_pkg::word_t       data_rdata,
    output logic                dc_cyc,
    output logic                dc_stb,
    output logic                dc_we,
    output wb_pkg::adr_t        dc_adr,
    output wb_pkg::sel_t        dc_sel,
    output wb_pkg::word_t       dc_dat_m,
    input  wire                 dc_ack,
    input  wire wb_pkg::word_t  dc_dat_s
);

    localparam logic LOOKUP = 1'b0;
    localparam logic BUS    = 1'b1;

    cache_pkg::cache_adr_u             req_adr;
    logic [cache_pkg::TAG_W-1:0]       tag_arr [cache_pkg::LINES];
    wb_pkg::word_t                     data_arr [cache_pkg::LINES];
    logic [cache_pkg::LINES-1:0]       valid;
    logic [cache_pkg::INDEX_W-1:0]     idx;
    logic                              state;
    logic                              start;
    logic                              hit;
    logic                              bus_done;

    assign req_adr.word = data_adr;
    assign idx      = req_adr.fields.index;
    assign hit      = valid[idx] && (tag_arr[idx] == req_adr.fields.tag);
    assign start    = (state == LOOKUP) && data_req && !data_ready;
    assign bus_done = (state == BUS) && dc_ack;

    // Master for read refills and write-through
    assign dc_cyc   = (state == BUS);
    assign dc_stb   = (state == BUS);
    assign dc_we    = data_we;
    assign dc_sel   = '1;
    assign dc_adr   = {req_adr.fields.tag, idx, {cache_pkg::OFFSET_W{1'b0}}};
    assign dc_dat_m = data_wdata;

    always_ff @(posedge wb_icache) begin
        if (rst) begin
            state      <= LOOKUP;
            data_ready <= 1'b0;
            valid      <= '0;
        end else begin
            data_ready <= 1'b0;
            if (start) begin
                if (!data_we && hit) begin
                    data_ready <= 1'b1;
                end else begin
                    state <= BUS;             // Misses and all writes
                end
            end else if (bus_done) begin
                if (!data_we) begin
                    valid[idx] <= 1'b1;       // No allocate on write
                end
                data_ready <= 1'b1;
                state      <= LOOKUP;
            end
        end
    end

    always_ff @(posedge wb_icache) begin
        if (start && hit) begin
            if (data_we) begin
                data_arr[idx] <= data_wdata;
            end else begin
                data_rdata <= data_arr[idx];
            end
        end
        if (bus_done && !data_we) begin
            tag_arr[idx]  <= req_adr.fields.tag;
            data_arr[idx] <= dc_dat_s;
            data_rdata    <= dc_dat_s;
        end
    end

endmodule : dcache

`default_nettype wire

//--- wb_sram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_sram #(
    parameter int MEM_WORDS   = 1024,
    parameter int WAIT_STATES = 2
) (
    input  wire                 wb_icache,
    input  wire                 rst,
    input  wire                 mem_cyc,
    input  wire                 mem_stb,
    input  wire                 mem_we,
    input  wire wb_pkg::adr_t   mem_adr,
    input  wire wb_pkg::sel_t   mem_sel,
    input  wire wb_pkg::word_t  mem_dat_m,
    output logic                mem_ack,
    output wb_pkg::word_t       mem_dat_s
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam wb_pkg::adr_t WORDS = MEM_WORDS;

    wb_pkg::word_t     mem [MEM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic [CNT_W-1:0]  wait_cnt;
    logic              access;

    assign idx    = IDX_W'((mem_adr >> 2) % WORDS);      // Word index, wraps
    assign access = mem_cyc && mem_stb && !mem_ack;

    always_ff @(posedge wb_icache) begin
        if (rst) begin
            mem_ack  <= 1'b0;
            wait_cnt <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            mem_ack <= 1'b0;
            if (access) begin
                if (wait_cnt == CNT_W'(WAIT_STATES)) begin
                    mem_ack   <= 1'b1;
                    wait_cnt  <= '0;
                    mem_dat_s <= mem[idx];
                    for (int b = 0; b < wb_pkg::DAT_W / 8; b++) begin
                        if (mem_we && mem_sel[b]) begin
                            mem[idx][8*b +: 8] <= mem_dat_m[8*b +: 8];
                        end
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end
        end
    end

endmodule : wb_sram

`default_nettype wire

//--- mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
    parameter int MEM_WORDS   = 1024,
    parameter int WAIT_STATES = 2
) (
    input  wire                 wb_icache,
    input  wire                 rst,
    input  wire                 fetch_req,
    input  wire wb_pkg::adr_t   fetch_adr,
    output wire                 fetch_ready,
    output wire wb_pkg::word_t  fetch_data,
    input  wire                 data_req,
    input  wire                 data_we,
    input  wire wb_pkg::adr_t   data_adr,
    input  wire wb_pkg::word_t  data_wdata,
    output wire                 data_ready,
    output wire wb_pkg::word_t  data_rdata
);

    wire                 ic_cyc;
    wire                 ic_stb;
    wire                 ic_we;
    wire wb_pkg::adr_t   ic_adr;
    wire wb_pkg::sel_t   ic_sel;
    wire wb_pkg::word_t  ic_dat_m;
    wire                 ic_ack;
    wire wb_pkg::word_t  ic_dat_s;

    wire                 dc_cyc;
    wire                 dc_stb;
    wire                 dc_we;
    wire wb_pkg::adr_t   dc_adr;
    wire wb_pkg::sel_t   dc_sel;
    wire wb_pkg::word_t  dc_dat_m;
    wire                 dc_ack;
    wire wb_pkg::word_t  dc_dat_s;

    wire                 mem_cyc;
    wire                 mem_stb;
    wire                 mem_we;
    wire wb_pkg::adr_t   mem_adr;
    wire wb_pkg::sel_t   mem_sel;
    wire wb_pkg::word_t  mem_dat_m;
    wire                 mem_ack;
    wire wb_pkg::word_t  mem_dat_s;

    icache u_icache (
        .wb_icache, .rst,
        .fetch_req, .fetch_adr, .fetch_ready, .fetch_data,
        .ic_cyc, .ic_stb, .ic_we, .ic_adr, .ic_sel, .ic_dat_m,
        .ic_ack, .ic_dat_s
    );

    dcache u_dcache (
        .wb_icache, .rst,
        .data_req, .data_we, .data_adr, .data_wdata, .data_ready, .data_rdata,
        .dc_cyc, .dc_stb, .dc_we, .dc_adr, .dc_sel, .dc_dat_m,
        .dc_ack, .dc_dat_s
    );

    wb_arbiter u_arbiter (
        .wb_icache, .rst,
        .ic_cyc, .ic_stb, .ic_we, .ic_adr, .ic_sel, .ic_dat_m, .ic_ack, .ic_dat_s,
        .dc_cyc, .dc_stb, .dc_we, .dc_adr, .dc_sel, .dc_dat_m, .dc_ack, .dc_dat_s,
        .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_sel, .mem_dat_m,
        .mem_ack, .mem_dat_s
    );

    wb_sram #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) u_sram (
        .wb_icache, .rst,
        .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_sel, .mem_dat_m,
        .mem_ack, .mem_dat_s
    );

endmodule : mem_subsys

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD = 20,               // 40 ns clock
    parameter int RST_CYCLES  = 2
) (
    output logic wb_icache,
    output logic rst
);

    initial begin
        wb_icache = 1'b0;
        forever #(HALF_PERIOD) wb_icache = ~wb_icache;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge wb_icache);
        #1 rst = 1'b0;                            // Released just after the last reset edge
    end

endmodule : tb_clkgen

`default_nettype wire

//--- tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int MEM_WORDS   = 1024;
    localparam int WAIT_STATES = 2;
    localparam int N_OPS       = 21;
    localparam int WAIT_LIMIT  = 4 * (WAIT_STATES + 3);
    localparam int CYCLE_LIMIT = N_OPS * WAIT_LIMIT + 20;

    localparam logic [1:0] P_INSTR = 2'd0;
    localparam logic [1:0] P_DATA  = 2'd1;
    localparam logic [1:0] P_BOTH  = 2'd2;       // Fetch and data read in the same cycle

    typedef struct packed {
        logic [1:0]   port;
        logic         we;
        wb_pkg::adr_t adr;
        logic         hit;
    } op_t;

    logic           wb_icache;
    logic           rst;
    logic           fetch_req;
    wb_pkg::adr_t   fetch_adr;
    wire            fetch_ready;
    wb_pkg::word_t  fetch_data;
    logic           data_req;
    logic           data_we;
    wb_pkg::adr_t   data_adr;
    wb_pkg::word_t  data_wdata;
    wire            data_ready;
    wb_pkg::word_t  data_rdata;

    wb_pkg::word_t  ref_mem [MEM_WORDS];
    wb_pkg::word_t  rng_state;
    int             data_errors;
    int             hit_errors;
    int             order_errors;
    int             ready_errors;
    int             cycle_count;

    // Index 0x100 / 0x3f00 share line 0, 0x40c / 0x80c share line 3
    op_t ops [N_OPS] = '{
        '{P_DATA,  1'b1, 32'h0000_0100, 1'b0},
        '{P_DATA,  1'b0, 32'h0000_0100, 1'b0},
        '{P_DATA,  1'b0, 32'h0000_0204, 1'b0},
        '{P_DATA,  1'b0, 32'h0000_0204, 1'b1},
        '{P_DATA,  1'b0, 32'h0000_0100, 1'b1},
        '{P_DATA,  1'b1, 32'h0000_0100, 1'b0},
        '{P_DATA,  1'b0, 32'h0000_0100, 1'b1},
        '{P_DATA,  1'b1, 32'h0000_0100, 1'b0},
        '{P_DATA,  1'b0, 32'h0000_0100, 1'b1},
        '{P_DATA,  1'b1, 32'h0000_0308, 1'b0},
        '{P_INSTR, 1'b0, 32'h0000_0308, 1'b0},
        '{P_INSTR, 1'b0, 32'h0000_0308, 1'b1},
        '{P_DATA,  1'b1, 32'h0000_040c, 1'b0},
        '{P_DATA,  1'b1, 32'h0000_080c, 1'b0},
        '{P_DATA,  1'b0, 32'h0000_040c, 1'b0},
        '{P_DATA,  1'b0, 32'h0000_080c, 1'b0},
        '{P_DATA,  1'b0, 32'h0000_040c, 1'b0},
        '{P_DATA,  1'b0, 32'h0000_080c, 1'b0},
        '{P_BOTH,  1'b0, 32'h0000_040c, 1'b0},
        '{P_BOTH,  1'b0, 32'h0000_080c, 1'b0},
        '{P_DATA,  1'b0, 32'h0000_3f00, 1'b0}
    };

    tb_clkgen u_clkgen (
        .wb_icache (wb_icache),
        .rst       (rst)
    );

    mem_subsys #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) UUT (
        .wb_icache   (wb_icache),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_adr   (fetch_adr),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .data_req    (data_req),
        .data_we     (data_we),
        .data_adr    (data_adr),
        .data_wdata  (data_wdata),
        .data_ready  (data_ready),
        .data_rdata  (data_rdata)
    );

    function automatic wb_pkg::word_t lcg_next(input wb_pkg::word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int word_index(input wb_pkg::adr_t a);
        return int'((a >> 2) % wb_pkg::adr_t'(MEM_WORDS));   // SRAM wraps on its size
    endfunction

    task automatic compare_word(input wb_pkg::word_t actual, input wb_pkg::word_t expected,
                                input string what);
        if (actual !== expected) begin
            data_errors++;
            $display("ERROR at %0t ns: %s returned 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic compare_hit(input bit actual, input bit expected, input string what);
        if (actual !== expected) begin
            hit_errors++;
            $display("ERROR at %0t ns: %s was a %s, expected a %s", $time, what,
                     actual ? "hit" : "miss", expected ? "hit" : "miss");
        end
    endtask

    task automatic fetch_once(input wb_pkg::adr_t adr, input bit exp_hit);
        int            lat;
        bit            seen;
        wb_pkg::word_t expected;
        expected  = ref_mem[word_index(adr)];
        fetch_adr = adr;
        fetch_req = 1'b1;
        lat       = 0;
        seen      = 1'b0;
        while (!seen && lat < WAIT_LIMIT) begin
            @(posedge wb_icache);
            #1;
            lat++;
            seen = fetch_ready;
        end
        fetch_req = 1'b0;
        if (!seen) begin
            ready_errors++;
            $display("Fetch from 0x%08h never got its ready within %0d cycles", adr, WAIT_LIMIT);
        end else begin
            compare_word(fetch_data, expected, "fetch");
            compare_hit(lat == 1, exp_hit, "fetch");
        end
    endtask

    task automatic data_access(input bit we, input wb_pkg::adr_t adr, input bit exp_hit);
        int            lat;
        bit            seen;
        wb_pkg::word_t expected;
        wb_pkg::word_t wdata;
        expected = ref_mem[word_index(adr)];
        wdata    = '0;
        if (we) begin
            rng_state = lcg_next(rng_state);
            wdata     = rng_state;
        end
        data_we    = we;
        data_adr   = adr;
        data_wdata = wdata;
        data_req   = 1'b1;
        lat        = 0;
        seen       = 1'b0;
        while (!seen && lat < WAIT_LIMIT) begin
            @(posedge wb_icache);
            #1;
            lat++;
            seen = data_ready;
        end
        data_req = 1'b0;
        data_we  = 1'b0;
        if (!seen) begin
            ready_errors++;
            $display("Data access to 0x%08h never got its ready within %0d cycles",
                     adr, WAIT_LIMIT);
        end else begin
            if (we) begin
                ref_mem[word_index(adr)] = wdata;    // Write-through lands in SRAM
            end else begin
                compare_word(data_rdata, expected, "data read");
            end
            compare_hit(lat == 1, exp_hit, we ? "data write" : "data read");
        end
    endtask

    task automatic paired_read(input wb_pkg::adr_t adr, input bit exp_hit);
        int            cyc;
        int            fetch_lat;
        int            data_lat;
        wb_pkg::word_t expected;
        expected   = ref_mem[word_index(adr)];
        fetch_adr  = adr;
        data_adr   = adr;
        data_we    = 1'b0;
        data_wdata = '0;
        fetch_req  = 1'b1;
        data_req   = 1'b1;
        fetch_lat  = 0;
        data_lat   = 0;
        cyc        = 0;
        while ((fetch_lat == 0 || data_lat == 0) && cyc < WAIT_LIMIT) begin
            @(posedge wb_icache);
            #1;
            cyc++;
            if (fetch_req && fetch_ready) begin
                fetch_lat = cyc;
                fetch_req = 1'b0;
                compare_word(fetch_data, expected, "paired fetch");
            end
            if (data_req && data_ready) begin
                data_lat = cyc;
                data_req = 1'b0;
                compare_word(data_rdata, expected, "paired data read");
            end
        end
        fetch_req = 1'b0;
        data_req  = 1'b0;
        if (fetch_lat == 0 || data_lat == 0) begin
            ready_errors++;
            $display("Paired access to 0x%08h did not finish on both ports within %0d cycles",
                     adr, WAIT_LIMIT);
        end else begin
            compare_hit(fetch_lat == 1, exp_hit, "paired fetch");
            compare_hit(data_lat == 1, exp_hit, "paired data read");
            if (fetch_lat > data_lat) begin
                order_errors++;
                $display("ERROR at %0t ns: fetch ready in cycle %0d came after data ready in %0d",
                         $time, fetch_lat, data_lat);
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge wb_icache);
            cycle_count++;
        end
        $display("Run stopped at the limit of %0d cycles before all operations finished",
                 CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int total;
        fetch_req    = 1'b0;
        fetch_adr    = '0;
        data_req     = 1'b0;
        data_we      = 1'b0;
        data_adr     = '0;
        data_wdata   = '0;
        rng_state    = 32'he0b5;
        data_errors  = 0;
        hit_errors   = 0;
        order_errors = 0;
        ready_errors = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;                      // SRAM clears on reset
        end
        @(negedge rst);
        for (int i = 0; i < N_OPS; i++) begin
            @(posedge wb_icache);
            #1;
            case (ops[i].port)
                P_INSTR: fetch_once(ops[i].adr, ops[i].hit);
                P_DATA:  data_access(ops[i].we, ops[i].adr, ops[i].hit);
                default: paired_read(ops[i].adr, ops[i].hit);
            endcase
        end
        @(posedge wb_icache);
        #1;
        total = data_errors + hit_errors + order_errors + ready_errors;
        $display("Done: %0d data errors, %0d hit errors, %0d order errors, %0d missing ready",
                 data_errors, hit_errors, order_errors, ready_errors);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_mem_subsys

`default_nettype wire

//--- compile.f
wb_pkg.sv
cache_pkg.sv
wb_arbiter.sv
icache.sv
dcache.sv
wb_sram.sv
mem_subsys.sv
tb_clkgen.sv
tb_mem_subsys.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_mem_subsys
FILELIST  := compile.f
OBJDIR    := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
